//--- Bender.yml
package:
  name: ctrl_in_mux

sources:
  - ctrl_in_cfg_pkg.sv
  - ctrl_in_seq_pkg.sv
  - ctrl_in_reg_decode.sv
  - ctrl_in_src_gen.sv
  - ctrl_in_trigger.sv
  - ctrl_in_flag_unit.sv
  - ctrl_in_mux.sv
  - target: simulation
    files:
      - tb_ctrl_in_mux.sv

//--- ctrl_in_cfg_pkg.sv
package ctrl_in_cfg_pkg;

    ////////////////////////////////////////////////////
    // word and field widths

    localparam int reg_width       = 32;
    localparam int num_ext_in      = 3;
    localparam int trg_sel_bits    = 4;
    localparam int num_trg_src     = 1 << trg_sel_bits;
    localparam int flag_sel_bits   = 5;
    // data-bit index plus the enable bit on top
    localparam int flag_field_bits = flag_sel_bits + 1;
    localparam int src_field_bits  = 8;
    // level, inverted level, rising and falling edge per input
    localparam int src_codes_per_in = 4;

    ////////////////////////////////////////////////////
    // field slots in units of src_field_bits

    // control word 0
    localparam int fld_trg_start   = 0;
    localparam int fld_trg_stop    = 1;
    localparam int fld_trg_restart = 2;
    // control word 1
    localparam int fld_nop         = 0;
    localparam int fld_irq         = 1;
    localparam int fld_strb        = 2;

    // trigger source codes
    typedef enum logic [trg_sel_bits-1:0] {
        src_none, src_in0, src_in0_inv, src_in0_pos, src_in0_neg,
        src_in1, src_in1_inv, src_in1_pos, src_in1_neg,
        src_in2, src_in2_inv, src_in2_pos, src_in2_neg,
        src_unused_13, src_unused_14, src_unused_15
    } src_code_e;

    typedef logic [reg_width-1:0] ctrl_word_t;

endpackage

//--- ctrl_in_flag_unit.sv
`timescale 1ns/1ps

module ctrl_in_flag_unit (
    input  logic                        clock_bus,
    input  logic                        reset_bus_n,
    input  ctrl_in_seq_pkg::flag_cfg_t  flag_cfg,
    input  ctrl_in_cfg_pkg::ctrl_word_t data,
    input  logic                        data_reload,
    input  logic                        first_sample,
    output logic                        data_nop,
    output logic                        data_stop,
    output logic                        data_irq
);

    logic nop_bit;
    logic stop_bit;
    logic irq_bit;
    logic strb_bit;
    logic strb_q;
    logic strb_repeat;
    logic nop_next;
    logic stop_next;
    logic irq_next;

    ////////////////////////////////////////////////////
    // bit selects from the current data word

    assign nop_bit  = data[flag_cfg.nop.idx];
    assign stop_bit = data[flag_cfg.stop.idx];
    assign irq_bit  = data[flag_cfg.irq.idx];
    assign strb_bit = data[flag_cfg.strb.idx];

    // strobe did not toggle since the last reload
    // the first sample has no history to compare against
    assign strb_repeat = flag_cfg.strb.en & ~first_sample & (strb_bit == strb_q);

    assign nop_next  = (flag_cfg.nop.en & nop_bit) | strb_repeat;
    assign stop_next = flag_cfg.stop.en & stop_bit;
    assign irq_next  = flag_cfg.irq.en & irq_bit;

    ////////////////////////////////////////////////////
    // flag registers updated only on reload

    always_ff @(posedge clock_bus) begin
        if (!reset_bus_n) begin
            data_nop  <= 1'b0;
            data_stop <= 1'b0;
            data_irq  <= 1'b0;
            strb_q    <= 1'b0;
        end else if (data_reload) begin
            data_nop  <= nop_next;
            data_stop <= stop_next;
            data_irq  <= irq_next;
            // history follows the data even with the strobe disabled
            strb_q    <= strb_bit;
        end
    end

endmodule

//--- ctrl_in_mux.f
ctrl_in_cfg_pkg.sv
ctrl_in_seq_pkg.sv
ctrl_in_reg_decode.sv
ctrl_in_src_gen.sv
ctrl_in_trigger.sv
ctrl_in_flag_unit.sv
ctrl_in_mux.sv
tb_ctrl_in_mux.sv

//--- ctrl_in_mux.sv
`timescale 1ns/1ps

module ctrl_in_mux (
    input  logic                                   clock_bus,
    input  logic                                   reset_bus_n,
    input  ctrl_in_cfg_pkg::ctrl_word_t            ctrl_in0,
    input  ctrl_in_cfg_pkg::ctrl_word_t            ctrl_in1,
    input  logic [ctrl_in_cfg_pkg::num_ext_in-1:0] ext_in,
    input  ctrl_in_seq_pkg::seq_state_t            seq_state,
    input  logic                                   data_reload,
    input  logic                                   first_sample,
    input  ctrl_in_cfg_pkg::ctrl_word_t            data,
    output ctrl_in_seq_pkg::trg_out_t              trg_start,
    output ctrl_in_seq_pkg::trg_out_t              trg_stop,
    output ctrl_in_seq_pkg::trg_out_t              trg_restart,
    output logic                                   data_nop,
    output logic                                   data_stop,
    output logic                                   data_irq
);

    import ctrl_in_cfg_pkg::*;
    import ctrl_in_seq_pkg::*;

    trg_cfg_t               trg_cfg;
    flag_cfg_t              flag_cfg;
    logic [num_trg_src-1:0] src;

    ctrl_in_reg_decode u_reg_decode (
        .ctrl_in0 (ctrl_in0),
        .ctrl_in1 (ctrl_in1),
        .trg_cfg  (trg_cfg),
        .flag_cfg (flag_cfg)
    );

    ctrl_in_src_gen u_src_gen (
        .clock_bus   (clock_bus),
        .reset_bus_n (reset_bus_n),
        .ext_in      (ext_in),
        .src         (src)
    );

    ////////////////////////////////////////////////////
    // trigger channels

    ctrl_in_trigger #(.kind(ctrl_in_seq_pkg::trg_start)) u_trg_start (
        .clock_bus   (clock_bus),
        .reset_bus_n (reset_bus_n),
        .sel         (trg_cfg.start),
        .src         (src),
        .seq_state   (seq_state),
        .trg         (trg_start)
    );

    ctrl_in_trigger #(.kind(ctrl_in_seq_pkg::trg_stop)) u_trg_stop (
        .clock_bus   (clock_bus),
        .reset_bus_n (reset_bus_n),
        .sel         (trg_cfg.stop),
        .src         (src),
        .seq_state   (seq_state),
        .trg         (trg_stop)
    );

    ctrl_in_trigger #(.kind(ctrl_in_seq_pkg::trg_restart)) u_trg_restart (
        .clock_bus   (clock_bus),
        .reset_bus_n (reset_bus_n),
        .sel         (trg_cfg.restart),
        .src         (src),
        .seq_state   (seq_state),
        .trg         (trg_restart)
    );

    ////////////////////////////////////////////////////
    // data flags

    ctrl_in_flag_unit u_flag_unit (
        .clock_bus    (clock_bus),
        .reset_bus_n  (reset_bus_n),
        .flag_cfg     (flag_cfg),
        .data         (data),
        .data_reload  (data_reload),
        .first_sample (first_sample),
        .data_nop     (data_nop),
        .data_stop    (data_stop),
        .data_irq     (data_irq)
    );

endmodule

//--- ctrl_in_reg_decode.sv
`timescale 1ns/1ps

module ctrl_in_reg_decode (
    input  ctrl_in_cfg_pkg::ctrl_word_t ctrl_in0,
    input  ctrl_in_cfg_pkg::ctrl_word_t ctrl_in1,
    output ctrl_in_seq_pkg::trg_cfg_t   trg_cfg,
    output ctrl_in_seq_pkg::flag_cfg_t  flag_cfg
);

    import ctrl_in_cfg_pkg::*;
    import ctrl_in_seq_pkg::*;

    logic [trg_sel_bits-1:0]    start_field;
    logic [trg_sel_bits-1:0]    restart_field;
    logic [flag_field_bits-1:0] stop_field;
    logic [flag_field_bits-1:0] nop_field;
    logic [flag_field_bits-1:0] irq_field;
    logic [flag_field_bits-1:0] strb_field;

    // enable sits above the data-bit index
    function automatic flag_sel_t to_flag_sel(input logic [flag_field_bits-1:0] field);
        flag_sel_t sel;
        sel.en  = field[flag_sel_bits];
        sel.idx = field[flag_sel_bits-1:0];
        return sel;
    endfunction

    assign start_field   = ctrl_in0[fld_trg_start*src_field_bits +: trg_sel_bits];
    assign restart_field = ctrl_in0[fld_trg_restart*src_field_bits +: trg_sel_bits];
    // stop field is shared by the stop trigger and the data stop flag
    assign stop_field    = ctrl_in0[fld_trg_stop*src_field_bits +: flag_field_bits];
    assign nop_field     = ctrl_in1[fld_nop*src_field_bits +: flag_field_bits];
    assign irq_field     = ctrl_in1[fld_irq*src_field_bits +: flag_field_bits];
    assign strb_field    = ctrl_in1[fld_strb*src_field_bits +: flag_field_bits];

    always_comb begin
        flag_cfg.nop  = to_flag_sel(nop_field);
        flag_cfg.stop = to_flag_sel(stop_field);
        flag_cfg.irq  = to_flag_sel(irq_field);
        flag_cfg.strb = to_flag_sel(strb_field);

        trg_cfg.start   = src_code_e'(start_field);
        trg_cfg.restart = src_code_e'(restart_field);
        // data stop mode takes the field away from the stop trigger
        if (stop_field[flag_sel_bits]) begin
            trg_cfg.stop = src_none;
        end else begin
            trg_cfg.stop = src_code_e'(stop_field[trg_sel_bits-1:0]);
        end
    end

endmodule

//--- ctrl_in_seq_pkg.sv
package ctrl_in_seq_pkg;

    // which arming rule a trigger channel follows
    typedef enum logic [1:0] {
        trg_start,
        trg_stop,
        trg_restart
    } trg_kind_e;

    // sequencer state as seen by the triggers
    typedef struct packed {
        logic run_en;
        logic state_run;
        logic state_wait;
        logic state_restart;
    } seq_state_t;

    typedef struct packed {
        logic en;
        logic pulse;
        logic tgl;
    } trg_out_t;

    ////////////////////////////////////////////////////
    // decoded configuration

    typedef struct packed {
        logic                                en;
        logic [ctrl_in_cfg_pkg::flag_sel_bits-1:0] idx;
    } flag_sel_t;

    typedef struct packed {
        flag_sel_t nop;
        flag_sel_t stop;
        flag_sel_t irq;
        flag_sel_t strb;
    } flag_cfg_t;

    typedef struct packed {
        ctrl_in_cfg_pkg::src_code_e start;
        ctrl_in_cfg_pkg::src_code_e stop;
        ctrl_in_cfg_pkg::src_code_e restart;
    } trg_cfg_t;

endpackage

//--- ctrl_in_src_gen.sv
`timescale 1ns/1ps

module ctrl_in_src_gen (
    input  logic                                    clock_bus,
    input  logic                                    reset_bus_n,
    input  logic [ctrl_in_cfg_pkg::num_ext_in-1:0]  ext_in,
    output logic [ctrl_in_cfg_pkg::num_trg_src-1:0] src
);

    import ctrl_in_cfg_pkg::*;

    logic [num_ext_in-1:0] ext_in_q;
    logic [num_ext_in-1:0] rise;
    logic [num_ext_in-1:0] fall;

    ////////////////////////////////////////////////////
    // edge detection

    // value of the inputs at the previous clock edge
    always_ff @(posedge clock_bus) begin
        if (!reset_bus_n) begin
            ext_in_q <= '0;
        end else begin
            ext_in_q <= ext_in;
        end
    end

    assign rise = ext_in & ~ext_in_q;
    assign fall = ~ext_in & ext_in_q;

    ////////////////////////////////////////////////////
    // source vector

    // each input owns four consecutive codes starting at src_in0
    always_comb begin
        src = '0;
        for (int i = 0; i < num_ext_in; i++) begin
            src[int'(src_in0) + src_codes_per_in*i]     = ext_in[i];
            src[int'(src_in0_inv) + src_codes_per_in*i] = ~ext_in[i];
            src[int'(src_in0_pos) + src_codes_per_in*i] = rise[i];
            src[int'(src_in0_neg) + src_codes_per_in*i] = fall[i];
        end
        // none and the unused codes stay low
    end

endmodule

//--- ctrl_in_trigger.sv
`timescale 1ns/1ps

module ctrl_in_trigger #(
    parameter ctrl_in_seq_pkg::trg_kind_e kind = ctrl_in_seq_pkg::trg_start
) (
    input  logic                                    clock_bus,
    input  logic                                    reset_bus_n,
    input  ctrl_in_cfg_pkg::src_code_e              sel,
    input  logic [ctrl_in_cfg_pkg::num_trg_src-1:0] src,
    input  ctrl_in_seq_pkg::seq_state_t             seq_state,
    output ctrl_in_seq_pkg::trg_out_t               trg
);

    import ctrl_in_cfg_pkg::*;
    import ctrl_in_seq_pkg::*;

    logic src_q;
    logic fired;
    logic tgl_q;
    logic en;
    logic armed;
    logic clear;
    logic pulse;

    // arming window depends on the channel kind
    always_comb begin
        case (kind)
            trg_start: armed = seq_state.run_en;
            trg_stop:  armed = seq_state.state_run & ~seq_state.state_wait;
            default:   armed = seq_state.state_wait;
        endcase
    end

    // start also rearms at the restart state of the sequencer
    assign clear = ~armed | ((kind == trg_start) & seq_state.state_restart);

    assign en    = (sel != src_none);
    assign pulse = src_q & en & armed & ~fired;

    ////////////////////////////////////////////////////
    // registered select, fired latch and toggle

    always_ff @(posedge clock_bus) begin
        if (!reset_bus_n) begin
            src_q <= 1'b0;
            fired <= 1'b0;
            tgl_q <= 1'b0;
        end else begin
            src_q <= src[sel];
            tgl_q <= tgl_q ^ pulse;
            // a pulse wins over the restart clear
            if (pulse) begin
                fired <= 1'b1;
            end else if (clear) begin
                fired <= 1'b0;
            end
        end
    end

    assign trg.en    = en;
    assign trg.pulse = pulse;
    assign trg.tgl   = tgl_q;

endmodule

//--- tb_ctrl_in_mux.sv
`timescale 1ns/1ps

module tb_ctrl_in_mux;

    import ctrl_in_cfg_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int wd_margin    = 20;

    // word 0 with start on in0_pos, stop on in1_inv and restart on in2
    localparam ctrl_word_t cw0_trg   = 32'h0009_0603;
    // same with the stop field in data-stop mode on bit 9
    localparam ctrl_word_t cw0_dstop = 32'h0009_2903;
    // word 1 with nop on bit 4, irq on bit 7 and strobe on bit 0
    localparam ctrl_word_t cw1_flags = 32'h0020_2724;

    // one table row applied for cnt cycles
    typedef struct packed {
        logic [7:0] cnt;
        ctrl_word_t c0;
        ctrl_word_t c1;
        logic [2:0] ext;
        logic [3:0] seq;
        ctrl_word_t data;
        logic       rld;
        logic       first;
        logic       rnd;
        logic [2:0] exp_pulse;
    } stim_row_t;

    logic                        clock_bus;
    logic                        reset_bus_n;
    ctrl_word_t                  ctrl_in0;
    ctrl_word_t                  ctrl_in1;
    logic [num_ext_in-1:0]       ext_in;
    ctrl_in_seq_pkg::seq_state_t seq_state;
    logic                        data_reload;
    logic                        first_sample;
    ctrl_word_t                  data;
    ctrl_in_seq_pkg::trg_out_t   trg_start;
    ctrl_in_seq_pkg::trg_out_t   trg_stop;
    ctrl_in_seq_pkg::trg_out_t   trg_restart;
    logic                        data_nop;
    logic                        data_stop;
    logic                        data_irq;

    stim_row_t stim_rows[$];
    int        total_cycles;

    // reference model state with start in bit 0, stop in bit 1 and restart in bit 2
    logic [2:0]            m_src_q;
    logic [2:0]            m_fired;
    logic [2:0]            m_tgl;
    logic [num_ext_in-1:0] m_ext_prev;
    logic                  m_nop;
    logic                  m_stop;
    logic                  m_irq;
    logic                  m_strb;

    ctrl_in_mux u_ctrl_in_mux (
        .clock_bus    (clock_bus),
        .reset_bus_n  (reset_bus_n),
        .ctrl_in0     (ctrl_in0),
        .ctrl_in1     (ctrl_in1),
        .ext_in       (ext_in),
        .seq_state    (seq_state),
        .data_reload  (data_reload),
        .first_sample (first_sample),
        .data         (data),
        .trg_start    (trg_start),
        .trg_stop     (trg_stop),
        .trg_restart  (trg_restart),
        .data_nop     (data_nop),
        .data_stop    (data_stop),
        .data_irq     (data_irq)
    );

    always #(clk_period/2) clock_bus = ~clock_bus;

    ////////////////////////////////////////////////////
    // reference model

    // select of a channel where the stop slot in data-stop mode selects nothing
    function automatic logic [3:0] chan_sel(input int ch, input ctrl_word_t c0);
        logic [7:0] fld;
        fld = c0[src_field_bits*ch +: src_field_bits];
        if (ch == 1 && fld[5]) begin
            return 4'd0;
        end
        return fld[3:0];
    endfunction

    // codes 1 to 12 are level, inverted, rising, falling for in0, in1, in2
    function automatic logic src_value(input logic [3:0] code, input logic [2:0] cur,
                                       input logic [2:0] prev);
        int i;
        if (code == 4'd0 || code > 4'd12) begin
            return 1'b0;
        end
        i = (code - 1) / 4;
        case ((code - 1) % 4)
            0:       return cur[i];
            1:       return ~cur[i];
            2:       return cur[i] & ~prev[i];
            default: return ~cur[i] & prev[i];
        endcase
    endfunction

    function automatic logic chan_armed(input int ch, input ctrl_in_seq_pkg::seq_state_t s);
        case (ch)
            0:       return s.run_en;
            1:       return s.state_run & ~s.state_wait;
            default: return s.state_wait;
        endcase
    endfunction

    // flag field has its enable in bit 5 and the data-bit index below
    function automatic logic flag_hit(input logic [7:0] fld, input ctrl_word_t word);
        return fld[5] & word[fld[4:0]];
    endfunction

    // advances the model by one clock edge with the inputs seen at that edge
    task automatic model_step();
        logic [3:0] sel;
        logic       armed;
        logic       pulse;
        logic [7:0] strb_fld;
        for (int ch = 0; ch < 3; ch++) begin
            sel   = chan_sel(ch, ctrl_in0);
            armed = chan_armed(ch, seq_state);
            pulse = m_src_q[ch] & (sel != 4'd0) & armed & ~m_fired[ch];
            m_tgl[ch] = m_tgl[ch] ^ pulse;
            if (pulse) begin
                m_fired[ch] = 1'b1;
            end else if (!armed || (ch == 0 && seq_state.state_restart)) begin
                m_fired[ch] = 1'b0;
            end
            m_src_q[ch] = src_value(sel, ext_in, m_ext_prev);
        end
        m_ext_prev = ext_in;
        if (data_reload) begin
            strb_fld = ctrl_in1[16 +: 8];
            m_nop  = flag_hit(ctrl_in1[7:0], data) |
                     (strb_fld[5] & ~first_sample & (data[strb_fld[4:0]] == m_strb));
            m_stop = flag_hit(ctrl_in0[15:8], data);
            m_irq  = flag_hit(ctrl_in1[15:8], data);
            m_strb = data[strb_fld[4:0]];
        end
    endtask

    ////////////////////////////////////////////////////
    // checks

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("CHECK FAILED at %0d ns: %s expected %0b actual %0b",
                     $time, name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // exp_pulse holds start, stop, restart from msb down
    task automatic check_outputs(input logic [2:0] exp_pulse);
        check_bit("trg_start.en", chan_sel(0, ctrl_in0) != 4'd0, trg_start.en);
        check_bit("trg_stop.en", chan_sel(1, ctrl_in0) != 4'd0, trg_stop.en);
        check_bit("trg_restart.en", chan_sel(2, ctrl_in0) != 4'd0, trg_restart.en);
        check_bit("trg_start.pulse", exp_pulse[2], trg_start.pulse);
        check_bit("trg_stop.pulse", exp_pulse[1], trg_stop.pulse);
        check_bit("trg_restart.pulse", exp_pulse[0], trg_restart.pulse);
        check_bit("trg_start.tgl", m_tgl[0], trg_start.tgl);
        check_bit("trg_stop.tgl", m_tgl[1], trg_stop.tgl);
        check_bit("trg_restart.tgl", m_tgl[2], trg_restart.tgl);
        check_bit("data_nop", m_nop, data_nop);
        check_bit("data_stop", m_stop, data_stop);
        check_bit("data_irq", m_irq, data_irq);
    endtask

    task automatic add_row(input logic [7:0] cnt, input ctrl_word_t c0, input ctrl_word_t c1,
                           input logic [2:0] ext, input logic [3:0] seq, input ctrl_word_t dat,
                           input logic rld, input logic first, input logic rnd,
                           input logic [2:0] exp_pulse);
        stim_rows.push_back({cnt, c0, c1, ext, seq, dat, rld, first, rnd, exp_pulse});
        total_cycles += cnt;
    endtask

    ////////////////////////////////////////////////////
    // stimulus table

    task automatic build_table();
        // cnt, word 0, word 1, ext_in, seq run/run_st/wait/restart, data, reload,
        // first, random data, expected pulses start/stop/restart
        // all trigger selects none before the channels get enabled
        add_row(1, 32'h0, cw1_flags, 3'b000, 4'b0000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b000, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b1000, 32'h0, 0, 0, 0, 3'b100);
        add_row(1, cw0_trg, cw1_flags, 3'b000, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        // second edge in the same arming period
        add_row(2, cw0_trg, cw1_flags, 3'b001, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b1001, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b000, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b1000, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b1000, 32'h0, 0, 0, 0, 3'b100);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b0000, 32'h0, 0, 0, 0, 3'b000);
        // stop on the inverted level of in1
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b0100, 32'h0, 0, 0, 0, 3'b010);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b0100, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b001, 4'b0110, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b101, 4'b0110, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b101, 4'b0110, 32'h0, 0, 0, 0, 3'b001);
        add_row(1, cw0_trg, cw1_flags, 3'b101, 4'b0110, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_trg, cw1_flags, 3'b101, 4'b0100, 32'h0, 0, 0, 0, 3'b010);
        add_row(1, cw0_trg, cw1_flags, 3'b101, 4'b0100, 32'h0, 0, 0, 0, 3'b000);
        // every flag disabled while random words reload
        add_row(2, cw0_trg, 32'h0, 3'b000, 4'b0100, 32'h0, 1, 0, 1, 3'b000);
        // data flags on random words with the stop trigger taken by data-stop mode
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 1, 1, 3'b000);
        add_row(2, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 0, 1, 3'b000);
        add_row(2, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 0, 0, 1, 3'b000);
        add_row(3, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 0, 1, 3'b000);
        // strobe on bit 0 repeating and toggling
        add_row(2, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h1, 1, 0, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 0, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 0, 0, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 1, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h0, 1, 0, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h10, 1, 0, 0, 3'b000);
        add_row(1, cw0_dstop, cw1_flags, 3'b000, 4'b0100, 32'h1, 0, 0, 0, 3'b000);
    endtask

    ////////////////////////////////////////////////////
    // main sequence

    initial begin
        int        seed_ret;
        stim_row_t r;
        clock_bus    = 1'b0;
        reset_bus_n  = 1'b0;
        ctrl_in0     = '0;
        ctrl_in1     = '0;
        ext_in       = '0;
        seq_state    = '0;
        data_reload  = 1'b0;
        first_sample = 1'b0;
        data         = '0;
        m_src_q      = '0;
        m_fired      = '0;
        m_tgl        = '0;
        m_ext_prev   = '0;
        m_nop        = 1'b0;
        m_stop       = 1'b0;
        m_irq        = 1'b0;
        m_strb       = 1'b0;
        total_cycles = 0;
        seed_ret     = $urandom(32'h8bac);
        build_table();

        repeat (reset_cycles) @(posedge clock_bus);
        reset_bus_n <= 1'b1;

        foreach (stim_rows[i]) begin
            r = stim_rows[i];
            repeat (r.cnt) begin
                @(posedge clock_bus);
                model_step();
                ctrl_in0     <= r.c0;
                ctrl_in1     <= r.c1;
                ext_in       <= r.ext;
                seq_state    <= ctrl_in_seq_pkg::seq_state_t'(r.seq);
                data_reload  <= r.rld;
                first_sample <= r.first;
                data         <= r.rnd ? ctrl_word_t'($urandom) : r.data;
                @(negedge clock_bus);
                check_outputs(r.exp_pulse);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    // bounded by the table length
    initial begin
        #1;
        #((total_cycles + reset_cycles + wd_margin) * clk_period);
        $display("watchdog expired before the stimulus table was done");
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation timeout");
    end

endmodule
